// ==== rtl/icache_pkg.sv ====
/* icache package
   geometry, bus response codes, FSM encoding and the two-way address view */
`default_nettype none

package icache_pkg;

  localparam int ADDR_W   = 32;
  localparam int DATA_W   = 64;  // fetch word and bus beat
  localparam int LINE_W   = 128;
  localparam int BEATS    = 2;
  localparam int BEAT_W   = $clog2(BEATS);
  localparam int OFFSET_W = 4;
  localparam int INDEX_W  = 6;
  localparam int SETS     = 64;
  localparam int TAG_W    = 22;
  localparam int WAYS     = 2;

  // controller states
  localparam logic [1:0] ST_IDLE    = 2'd0;
  localparam logic [1:0] ST_LOOKUP  = 2'd1;
  localparam logic [1:0] ST_REFILL  = 2'd2;
  localparam logic [1:0] ST_RESPOND = 2'd3;

  // ordered so a larger code is the worse outcome
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_e;

  typedef union packed {
    struct packed {
      logic [TAG_W-1:0]             tag;
      logic [INDEX_W-1:0]           index;
      logic                         word;      // which half of the line
      logic [$clog2(DATA_W/8)-1:0]  byte_off;
    } lookup;
    struct packed {
      logic [ADDR_W-OFFSET_W-1:0]   line;
      logic [OFFSET_W-1:0]          offset;
    } refill;
  } addr_u;

endpackage

`default_nettype wire

// ==== rtl/icache_refill_if.sv ====
/* icache refill interface
   line request from the controller, returned beats toward array and controller */
`timescale 1ns/10ps
`default_nettype none

interface icache_refill_if;

  logic                              start;      // one-cycle pulse
  icache_pkg::addr_u                 line_addr;
  logic                              beat_we;    // pulse per beat
  logic [icache_pkg::BEAT_W-1:0]     beat_idx;
  logic [icache_pkg::DATA_W-1:0]     beat_data;
  icache_pkg::resp_e                 resp;       // worst of the burst so far
  logic                              done;       // pulse after last beat

  modport ctrl   (output start, line_addr,
                  input  beat_we, beat_idx, beat_data, resp, done);
  modport engine (input  start, line_addr,
                  output beat_we, beat_idx, beat_data, resp, done);
  modport array  (input  beat_we, beat_idx, beat_data);

endinterface

`default_nettype wire

// ==== rtl/icache_tag_array.sv ====
/* icache tag array
   per-way tags and valid bits, registered lookup, hit compare and victim pick */
`timescale 1ns/10ps
`default_nettype none

module icache_tag_array (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           flush_i,
  input  logic [icache_pkg::INDEX_W-1:0] lookup_index_i,
  input  logic [icache_pkg::TAG_W-1:0]   lookup_tag_i,
  input  logic                           fill_we_i,
  input  logic                           fill_way_i,
  input  logic [icache_pkg::INDEX_W-1:0] fill_index_i,
  input  logic [icache_pkg::TAG_W-1:0]   fill_tag_i,
  input  logic                           fill_valid_i,
  output logic                           hit_o,
  output logic                           hit_way_o,
  output logic                           victim_way_o
);

  logic [icache_pkg::TAG_W-1:0]                        tag_mem [icache_pkg::WAYS][icache_pkg::SETS];
  logic [icache_pkg::WAYS-1:0][icache_pkg::SETS-1:0]  valid_q;

  logic [icache_pkg::TAG_W-1:0] rd_tag_q [icache_pkg::WAYS];
  logic [icache_pkg::WAYS-1:0]  rd_valid_q;
  logic [icache_pkg::TAG_W-1:0] cmp_tag_q;   // tag of the access being looked up
  logic [icache_pkg::WAYS-1:0]  hit_vec;
  logic                         victim_q;

  // valid bits, flush wins over a fill
  always_ff @(posedge clk) begin
    if (rst || flush_i) begin
      valid_q <= '0;
    end else if (fill_we_i) begin
      valid_q[fill_way_i][fill_index_i] <= fill_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid_q <= '0;
    end else begin
      for (int w = 0; w < icache_pkg::WAYS; w++) begin
        rd_valid_q[w] <= valid_q[w][lookup_index_i];
      end
    end
  end

  // tag storage, synchronous read of both ways
  always_ff @(posedge clk) begin
    if (fill_we_i) begin
      tag_mem[fill_way_i][fill_index_i] <= fill_tag_i;
    end
    for (int w = 0; w < icache_pkg::WAYS; w++) begin
      rd_tag_q[w] <= tag_mem[w][lookup_index_i];
    end
    cmp_tag_q <= lookup_tag_i;
  end

  always_comb begin
    for (int w = 0; w < icache_pkg::WAYS; w++) begin
      hit_vec[w] = rd_valid_q[w] && (rd_tag_q[w] == cmp_tag_q);
    end
  end

  assign hit_o     = |hit_vec;
  assign hit_way_o = hit_vec[1];  // two ways only

  // free-running toggle gives pseudo random replacement
  always_ff @(posedge clk) begin
    if (rst) begin
      victim_q <= 1'b0;
    end else begin
      victim_q <= ~victim_q;
    end
  end

  assign victim_way_o = victim_q;

endmodule

`default_nettype wire

// ==== rtl/icache_data_array.sv ====
/* icache data array
   two ways of 128-bit lines, synchronous read, half-line writes during refill */
`timescale 1ns/10ps
`default_nettype none

module icache_data_array (
  input  logic                           clk,
  input  logic [icache_pkg::INDEX_W-1:0] rd_index_i,
  input  logic                           rd_way_i,
  input  logic                           rd_word_i,
  output logic [icache_pkg::DATA_W-1:0]  rd_data_o,
  input  logic                           fill_way_i,
  input  logic [icache_pkg::INDEX_W-1:0] fill_index_i,
  icache_refill_if.array                 rf
);

  logic [icache_pkg::LINE_W-1:0] rd_line_q [icache_pkg::WAYS];
  logic [icache_pkg::LINE_W-1:0] sel_line;

  for (genvar w = 0; w < icache_pkg::WAYS; w++) begin : g_way
    logic [icache_pkg::LINE_W-1:0] line_mem [icache_pkg::SETS];
    logic                          way_we;

    assign way_we = rf.beat_we && (fill_way_i == 1'(w));

    always_ff @(posedge clk) begin
      if (way_we) begin
        // beat 0 is the low half
        line_mem[fill_index_i][rf.beat_idx*icache_pkg::DATA_W +: icache_pkg::DATA_W]
          <= rf.beat_data;
      end
      rd_line_q[w] <= line_mem[rd_index_i];
    end
  end

  // way is only known after the tag read, so pick it here
  assign sel_line  = rd_line_q[rd_way_i];
  assign rd_data_o = rd_word_i ? sel_line[icache_pkg::LINE_W-1:icache_pkg::DATA_W]
                               : sel_line[icache_pkg::DATA_W-1:0];

endmodule

`default_nettype wire

// ==== rtl/icache_refill.sv ====
/* icache refill engine
   issues the line read on the memory bus and collects two beats with responses */
`timescale 1ns/10ps
`default_nettype none

module icache_refill (
  input  logic                           clk,
  input  logic                           rst,
  icache_refill_if.engine                rf,
  output logic                           mem_ar_valid_o,
  input  logic                           mem_ar_ready_i,
  output logic [icache_pkg::ADDR_W-1:0]  mem_ar_addr_o,
  input  logic                           mem_r_valid_i,
  output logic                           mem_r_ready_o,
  input  logic [icache_pkg::DATA_W-1:0]  mem_r_data_i,
  input  logic [1:0]                     mem_r_resp_i,
  input  logic                           mem_r_last_i
);

  icache_pkg::addr_u             ar_addr_q;
  icache_pkg::resp_e             worst_q;
  icache_pkg::resp_e             beat_resp;
  logic [icache_pkg::BEAT_W-1:0] beat_q;
  logic                          done_q;
  logic                          r_fire;

  assign r_fire    = mem_r_valid_i && mem_r_ready_o;
  assign beat_resp = icache_pkg::resp_e'(mem_r_resp_i);

  // ar_valid and r_ready double as the phase of the burst
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_ar_valid_o <= 1'b0;
      mem_r_ready_o  <= 1'b0;
      done_q         <= 1'b0;
      beat_q         <= '0;
    end else begin
      done_q <= 1'b0;
      if (rf.start) begin
        mem_ar_valid_o <= 1'b1;
        beat_q         <= '0;
      end else if (mem_ar_valid_o && mem_ar_ready_i) begin
        mem_ar_valid_o <= 1'b0;
        mem_r_ready_o  <= 1'b1;
      end
      if (r_fire) begin
        beat_q <= beat_q + 1'b1;
        if (mem_r_last_i) begin
          mem_r_ready_o <= 1'b0;
          done_q        <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rf.start) begin
      ar_addr_q.refill.line   <= rf.line_addr.refill.line;
      ar_addr_q.refill.offset <= '0;  // line aligned
      worst_q                 <= icache_pkg::OKAY;
    end else if (r_fire && (beat_resp > worst_q)) begin
      worst_q <= beat_resp;
    end
  end

  assign mem_ar_addr_o = ar_addr_q;

  assign rf.beat_we   = r_fire;
  assign rf.beat_idx  = beat_q;
  assign rf.beat_data = mem_r_data_i;
  assign rf.resp      = worst_q;
  assign rf.done      = done_q;

endmodule

`default_nettype wire

// ==== rtl/icache_ctrl.sv ====
/* icache controller
   core handshake, two-cycle lookup, miss handling and returned word select */
`timescale 1ns/10ps
`default_nettype none

module icache_ctrl (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           req_valid_i,
  output logic                           req_ready_o,
  input  icache_pkg::addr_u              req_addr_i,
  output logic                           rsp_valid_o,
  input  logic                           rsp_ready_i,
  output logic [icache_pkg::DATA_W-1:0]  rsp_data_o,
  output icache_pkg::resp_e              rsp_resp_o,
  input  logic                           flush_i,
  output logic [icache_pkg::INDEX_W-1:0] lookup_index_o,
  output logic [icache_pkg::TAG_W-1:0]   lookup_tag_o,
  output logic                           fill_we_o,
  output logic                           fill_way_o,
  output logic [icache_pkg::INDEX_W-1:0] fill_index_o,
  output logic [icache_pkg::TAG_W-1:0]   fill_tag_o,
  output logic                           fill_valid_o,
  input  logic                           hit_i,
  input  logic                           victim_way_i,
  output logic                           rd_word_o,
  input  logic [icache_pkg::DATA_W-1:0]  rd_data_i,
  icache_refill_if.ctrl                  rf
);

  logic [1:0]        state_q;
  icache_pkg::addr_u addr_q;
  logic              tag_rdy_q;  // arrays hold the read for addr_q
  logic              way_q;
  logic              start_q;
  logic              accept;
  logic              lookup_done;
  logic              miss;
  logic              in_refill;

  assign accept      = req_valid_i && req_ready_o;
  assign lookup_done = (state_q == icache_pkg::ST_LOOKUP) && tag_rdy_q;
  assign miss        = lookup_done && !hit_i;
  assign in_refill   = (state_q == icache_pkg::ST_REFILL);

  assign req_ready_o = (state_q == icache_pkg::ST_IDLE) && !flush_i;

  assign lookup_index_o = addr_q.lookup.index;
  assign lookup_tag_o   = addr_q.lookup.tag;
  assign rd_word_o      = addr_q.lookup.word;

  // tag goes in with valid clear on the miss, valid follows on done
  assign fill_we_o    = miss || (in_refill && rf.done);
  assign fill_way_o   = miss ? victim_way_i : way_q;
  assign fill_index_o = addr_q.lookup.index;
  assign fill_tag_o   = addr_q.lookup.tag;
  assign fill_valid_o = in_refill && (rf.resp == icache_pkg::OKAY);

  assign rf.start     = start_q;
  assign rf.line_addr = addr_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= icache_pkg::ST_IDLE;
      tag_rdy_q   <= 1'b0;
      start_q     <= 1'b0;
      rsp_valid_o <= 1'b0;
    end else begin
      start_q <= 1'b0;
      case (state_q)
        icache_pkg::ST_IDLE: begin
          tag_rdy_q <= 1'b0;
          if (accept) state_q <= icache_pkg::ST_LOOKUP;
        end
        icache_pkg::ST_LOOKUP: begin
          tag_rdy_q <= 1'b1;
          if (lookup_done && hit_i) begin
            state_q     <= icache_pkg::ST_RESPOND;
            rsp_valid_o <= 1'b1;
          end else if (miss) begin
            state_q <= icache_pkg::ST_REFILL;
            start_q <= 1'b1;
          end
        end
        icache_pkg::ST_REFILL: begin
          if (rf.done) begin
            state_q     <= icache_pkg::ST_RESPOND;
            rsp_valid_o <= 1'b1;
          end
        end
        default: begin  // respond, hold until the core takes it
          if (rsp_ready_i) begin
            state_q     <= icache_pkg::ST_IDLE;
            rsp_valid_o <= 1'b0;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) addr_q <= req_addr_i;
    if (miss) way_q <= victim_way_i;
    if (lookup_done && hit_i) begin
      rsp_data_o <= rd_data_i;
      rsp_resp_o <= icache_pkg::OKAY;
    end
    // requested word straight from the bus beat
    if (in_refill && rf.beat_we && (rf.beat_idx == addr_q.lookup.word)) begin
      rsp_data_o <= rf.beat_data;
    end
    if (in_refill && rf.done) rsp_resp_o <= rf.resp;
  end

endmodule

`default_nettype wire

// ==== rtl/icache_top.sv ====
/* icache top
   read-only 2-way instruction cache with a core port and a burst memory port */
`timescale 1ns/10ps
`default_nettype none

module icache_top (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           flush_i,
  // core side
  input  logic                           req_valid_i,
  output logic                           req_ready_o,
  input  logic [icache_pkg::ADDR_W-1:0]  req_addr_i,
  output logic                           rsp_valid_o,
  input  logic                           rsp_ready_i,
  output logic [icache_pkg::DATA_W-1:0]  rsp_data_o,
  output logic [1:0]                     rsp_resp_o,
  // memory side
  output logic                           mem_ar_valid_o,
  input  logic                           mem_ar_ready_i,
  output logic [icache_pkg::ADDR_W-1:0]  mem_ar_addr_o,
  input  logic                           mem_r_valid_i,
  output logic                           mem_r_ready_o,
  input  logic [icache_pkg::DATA_W-1:0]  mem_r_data_i,
  input  logic [1:0]                     mem_r_resp_i,
  input  logic                           mem_r_last_i
);

  logic [icache_pkg::INDEX_W-1:0] lookup_index;
  logic [icache_pkg::TAG_W-1:0]   lookup_tag;
  logic                           fill_we;
  logic                           fill_way;
  logic [icache_pkg::INDEX_W-1:0] fill_index;
  logic [icache_pkg::TAG_W-1:0]   fill_tag;
  logic                           fill_valid;
  logic                           hit;
  logic                           hit_way;
  logic                           victim_way;
  logic                           rd_word;
  logic [icache_pkg::DATA_W-1:0]  rd_data;

  icache_refill_if rf ();

  icache_ctrl u_ctrl (
    .clk, .rst, .req_valid_i, .req_ready_o, .req_addr_i (req_addr_i),
    .rsp_valid_o, .rsp_ready_i, .rsp_data_o, .rsp_resp_o (rsp_resp_o), .flush_i,
    .lookup_index_o (lookup_index), .lookup_tag_o (lookup_tag),
    .fill_we_o (fill_we), .fill_way_o (fill_way), .fill_index_o (fill_index),
    .fill_tag_o (fill_tag), .fill_valid_o (fill_valid),
    .hit_i (hit), .victim_way_i (victim_way),
    .rd_word_o (rd_word), .rd_data_i (rd_data), .rf (rf.ctrl)
  );

  icache_tag_array u_tag_array (
    .clk, .rst, .flush_i,
    .lookup_index_i (lookup_index), .lookup_tag_i (lookup_tag),
    .fill_we_i (fill_we), .fill_way_i (fill_way), .fill_index_i (fill_index),
    .fill_tag_i (fill_tag), .fill_valid_i (fill_valid),
    .hit_o (hit), .hit_way_o (hit_way), .victim_way_o (victim_way)
  );

  icache_data_array u_data_array (
    .clk, .rd_index_i (lookup_index), .rd_way_i (hit_way), .rd_word_i (rd_word),
    .rd_data_o (rd_data), .fill_way_i (fill_way), .fill_index_i (fill_index),
    .rf (rf.array)
  );

  icache_refill u_refill (
    .clk, .rst, .rf (rf.engine),
    .mem_ar_valid_o, .mem_ar_ready_i, .mem_ar_addr_o,
    .mem_r_valid_i, .mem_r_ready_o, .mem_r_data_i, .mem_r_resp_i, .mem_r_last_i
  );

endmodule

`default_nettype wire

// ==== sim/tb_mem_model.sv ====
/* burst memory model for the icache testbench
   two-beat line reads with random stalls, pattern data and an error window */
`timescale 1ns/10ps
`default_nettype none

module tb_mem_model #(
  parameter logic [63:0] PATTERN   = 64'h0,
  parameter logic [31:0] ERR_BASE  = 32'h0,
  parameter logic [31:0] ERR_LIMIT = 32'h0
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        ar_valid_i,
  output logic        ar_ready_o,
  input  logic [31:0] ar_addr_i,
  output logic        r_valid_o,
  input  logic        r_ready_i,
  output logic [63:0] r_data_o,
  output logic [1:0]  r_resp_o,
  output logic        r_last_o
);

  logic        busy_q;
  logic [31:0] line_q;
  logic        beat_q;  // two beats per line
  logic        in_window;

  always @(posedge clk) begin
    if (rst) begin
      ar_ready_o <= 1'b0;
      r_valid_o  <= 1'b0;
      busy_q     <= 1'b0;
      beat_q     <= 1'b0;
      line_q     <= '0;
    end else if (!busy_q) begin
      ar_ready_o <= ($urandom % 4) != 0;  // stall about one cycle in four
      if (ar_valid_i && ar_ready_o) begin
        busy_q     <= 1'b1;
        line_q     <= {ar_addr_i[31:4], 4'h0};
        beat_q     <= 1'b0;
        ar_ready_o <= 1'b0;
      end
    end else if (r_valid_o && r_ready_i) begin
      r_valid_o <= 1'b0;
      beat_q    <= ~beat_q;
      if (beat_q) busy_q <= 1'b0;
    end else if (!r_valid_o) begin
      r_valid_o <= ($urandom % 3) != 0;
    end
  end

  assign in_window = (line_q >= ERR_BASE) && (line_q < ERR_LIMIT);

  assign r_data_o = {32'h0, line_q} ^ PATTERN ^ 64'(beat_q);
  assign r_resp_o = in_window ? icache_pkg::SLVERR : icache_pkg::OKAY;
  assign r_last_o = beat_q;

endmodule

`default_nettype wire

// ==== sim/tb_icache_top.sv ====
/* icache testbench
   directed fetch tests against the burst memory model */
`timescale 1ns/10ps
`default_nettype none

module tb_icache_top;

  localparam int          CLK_PERIOD    = 40;
  localparam int          RESET_CYCLES  = 5;
  localparam int          NUM_TESTS     = 6;
  localparam int          MAX_ACCESSES  = 12;  // per test
  localparam int          ACCESS_BUDGET = 50;  // cycles per access
  localparam int unsigned SEED          = 32'h0a209db7;
  localparam logic [63:0] PATTERN       = 64'h5a3c_96e1_0f87_d2b4;
  localparam logic [31:0] ERR_BASE      = 32'h0080_0000;  // lines answering SLVERR
  localparam logic [31:0] ERR_LIMIT     = 32'h0080_1000;
  localparam int          EXP_HIT       = 0;
  localparam int          EXP_MISS      = 1;
  localparam int          EXP_ANY       = 2;

  logic        clk;
  logic        rst;
  logic        flush;
  logic        req_valid;
  logic        req_ready;
  logic [31:0] req_addr;
  logic        rsp_valid;
  logic        rsp_ready;
  logic [63:0] rsp_data;
  logic [1:0]  rsp_resp;
  logic        ar_valid;
  logic        ar_ready;
  logic [31:0] ar_addr;
  logic        r_valid;
  logic        r_ready;
  logic [63:0] r_data;
  logic [1:0]  r_resp;
  logic        r_last;

  int unsigned edge_cnt = 0;
  int unsigned ar_count = 0;  // address handshakes seen on the memory port
  logic [31:0] last_ar_addr = '0;
  int unsigned accept_edge = 0;

  icache_top u_icache_top (
    .clk, .rst, .flush_i (flush),
    .req_valid_i (req_valid), .req_ready_o (req_ready), .req_addr_i (req_addr),
    .rsp_valid_o (rsp_valid), .rsp_ready_i (rsp_ready),
    .rsp_data_o (rsp_data), .rsp_resp_o (rsp_resp),
    .mem_ar_valid_o (ar_valid), .mem_ar_ready_i (ar_ready), .mem_ar_addr_o (ar_addr),
    .mem_r_valid_i (r_valid), .mem_r_ready_o (r_ready), .mem_r_data_i (r_data),
    .mem_r_resp_i (r_resp), .mem_r_last_i (r_last)
  );

  tb_mem_model #(.PATTERN (PATTERN), .ERR_BASE (ERR_BASE), .ERR_LIMIT (ERR_LIMIT)) u_mem (
    .clk, .rst,
    .ar_valid_i (ar_valid), .ar_ready_o (ar_ready), .ar_addr_i (ar_addr),
    .r_valid_o (r_valid), .r_ready_i (r_ready), .r_data_o (r_data),
    .r_resp_o (r_resp), .r_last_o (r_last)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) edge_cnt <= edge_cnt + 1;

  always @(posedge clk) begin
    if (!rst && ar_valid && ar_ready) begin
      ar_count     <= ar_count + 1;
      last_ar_addr <= ar_addr;
    end
  end

  initial begin
    repeat (RESET_CYCLES + NUM_TESTS * MAX_ACCESSES * ACCESS_BUDGET) @(posedge clk);
    $display("watchdog expired, the tests did not finish in time");
    $display("TEST FAIL");
    $fatal(1);
  end

  task automatic compare(input string test, input string what,
                         input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      $display("[ERROR] %s %s: expected %0h, actual %0h", test, what, exp, act);
      $display("TEST FAIL");
      $fatal(1);
    end
  endtask

  function automatic logic [31:0] make_addr(input logic [icache_pkg::TAG_W-1:0] tag,
                                            input logic [icache_pkg::INDEX_W-1:0] index,
                                            input logic word);
    icache_pkg::addr_u a;
    a = '0;
    a.lookup.tag   = tag;
    a.lookup.index = index;
    a.lookup.word  = word;
    return a;
  endfunction

  function automatic logic [31:0] line_of(input logic [31:0] addr);
    return (addr >> icache_pkg::OFFSET_W) << icache_pkg::OFFSET_W;
  endfunction

  // line address xor pattern xor beat index (beat 0 is the low word)
  function automatic logic [63:0] pattern_word(input logic [31:0] addr);
    return {32'h0, line_of(addr)} ^ PATTERN ^ 64'(addr[3]);
  endfunction

  function automatic logic [1:0] expected_resp(input logic [31:0] addr);
    if (line_of(addr) >= ERR_BASE && line_of(addr) < ERR_LIMIT) return icache_pkg::SLVERR;
    return icache_pkg::OKAY;
  endfunction

  // one request, optional response stall, returns edges to rsp_valid and memory requests
  task automatic fetch(input string test, input logic [31:0] addr, input int hold,
                       output logic [63:0] data, output logic [1:0] resp,
                       output int lat, output int reqs);
    int unsigned start_reqs;
    logic        rdy;
    start_reqs = ar_count;
    rsp_ready  = (hold == 0);
    req_valid  = 1'b1;
    req_addr   = addr;
    rdy        = 1'b0;
    while (!rdy) begin
      @(negedge clk);
      rdy = req_ready;
      @(posedge clk);
    end
    #2;
    accept_edge = edge_cnt;
    req_valid   = 1'b0;
    lat         = 0;
    @(negedge clk);
    while (!rsp_valid) begin
      @(posedge clk);
      lat++;
      @(negedge clk);
    end
    data = rsp_data;
    resp = rsp_resp;
    if (hold > 0) begin
      repeat (hold) begin
        @(posedge clk);
        @(negedge clk);
        compare(test, "rsp_valid held", 64'd1, 64'(rsp_valid));
        compare(test, "held data", data, rsp_data);
        compare(test, "held resp", 64'(resp), 64'(rsp_resp));
        compare(test, "req_ready while busy", 64'd0, 64'(req_ready));
      end
      @(posedge clk);
      #2 rsp_ready = 1'b1;
    end
    @(posedge clk);
    #2;
    reqs = int'(ar_count - start_reqs);
  endtask

  task automatic access(input string test, input logic [31:0] addr, input int hold,
                        input int expect_kind);
    logic [63:0] data;
    logic [1:0]  resp;
    int          lat;
    int          reqs;
    int          exp_reqs;
    fetch(test, addr, hold, data, resp, lat, reqs);
    if (expect_kind == EXP_HIT) begin
      exp_reqs = 0;
    end else if (expect_kind == EXP_MISS) begin
      exp_reqs = 1;
    end else begin
      exp_reqs = int'(lat > 2);  // one request per observed miss
    end
    compare(test, "data", pattern_word(addr), data);
    compare(test, "resp", 64'(expected_resp(addr)), 64'(resp));
    compare(test, "memory requests", 64'(exp_reqs), 64'(reqs));
    if (reqs != 0) compare(test, "line address", 64'(line_of(addr)), 64'(last_ar_addr));
    if (expect_kind == EXP_HIT) begin
      compare(test, "hit latency", 64'd2, 64'(lat));
    end else if (expect_kind == EXP_MISS) begin
      compare(test, "miss", 64'd1, 64'(lat > 2));
    end
  endtask

  // victim counter steps every edge, so accept parity picks the fill way
  task automatic align_accept(input logic parity);
    if (1'(edge_cnt + 1) != parity) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic cold_miss();
    access("cold_miss", make_addr(22'h00123, 6'd5, 1'b0), 0, EXP_MISS);
  endtask

  task automatic hit_latency();
    access("hit_latency", make_addr(22'h00123, 6'd5, 1'b0), 0, EXP_HIT);
    access("hit_latency", make_addr(22'h00123, 6'd5, 1'b1), 0, EXP_HIT);
  endtask

  task automatic two_way_set();
    logic [31:0] addr_a;
    logic [31:0] addr_b;
    logic [31:0] addr_c;
    addr_a = make_addr(22'h00200, 6'd17, 1'b0);
    addr_b = make_addr(22'h00345, 6'd17, 1'b1);
    addr_c = make_addr(22'h00abc, 6'd17, 1'b0);
    access("two_way_set", addr_a, 0, EXP_MISS);
    align_accept(!accept_edge[0]);  // second line into the other way
    access("two_way_set", addr_b, 0, EXP_MISS);
    access("two_way_set", addr_a, 0, EXP_HIT);
    access("two_way_set", addr_b, 0, EXP_HIT);
    access("two_way_set", addr_c, 0, EXP_MISS);
    repeat (2) begin
      access("two_way_set", addr_a, 0, EXP_ANY);
      access("two_way_set", addr_b, 0, EXP_ANY);
      access("two_way_set", addr_c, 0, EXP_ANY);
    end
  endtask

  task automatic rsp_backpressure();
    access("rsp_backpressure", make_addr(22'h00123, 6'd5, 1'b1), 5, EXP_HIT);
    access("rsp_backpressure", make_addr(22'h01777, 6'd40, 1'b1), 4, EXP_MISS);
  endtask

  task automatic refill_error();
    access("refill_error", 32'h0080_0208, 0, EXP_MISS);
    access("refill_error", 32'h0080_0208, 0, EXP_MISS);  // line was never installed
    access("refill_error", 32'h0080_0200, 0, EXP_MISS);
  endtask

  task automatic flush_test();
    access("flush", make_addr(22'h00123, 6'd5, 1'b0), 0, EXP_HIT);
    flush = 1'b1;
    @(negedge clk);
    compare("flush", "req_ready during flush", 64'd0, 64'(req_ready));
    @(posedge clk);
    #2 flush = 1'b0;
    access("flush", make_addr(22'h00123, 6'd5, 1'b0), 0, EXP_MISS);
    access("flush", make_addr(22'h00123, 6'd5, 1'b0), 0, EXP_HIT);
  endtask

  initial begin
    int unsigned seed;
    seed = SEED;
    void'($urandom(seed));
    rst       = 1'b1;
    flush     = 1'b0;
    req_valid = 1'b0;
    req_addr  = '0;
    rsp_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #2 rst = 1'b0;
    @(negedge clk);
    compare("reset", "req_ready", 64'd1, 64'(req_ready));
    compare("reset", "rsp_valid", 64'd0, 64'(rsp_valid));
    compare("reset", "mem_ar_valid", 64'd0, 64'(ar_valid));
    compare("reset", "mem_r_ready", 64'd0, 64'(r_ready));
    @(posedge clk);
    #2;
    cold_miss();
    hit_latency();
    two_way_set();
    rsp_backpressure();
    refill_error();
    flush_test();
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
rtl/icache_pkg.sv
rtl/icache_refill_if.sv
rtl/icache_tag_array.sv
rtl/icache_data_array.sv
rtl/icache_refill.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
sim/tb_mem_model.sv
sim/tb_icache_top.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  - rtl/icache_pkg.sv
  - rtl/icache_refill_if.sv
  - rtl/icache_tag_array.sv
  - rtl/icache_data_array.sv
  - rtl/icache_refill.sv
  - rtl/icache_ctrl.sv
  - rtl/icache_top.sv
  - target: simulation
    files:
      - sim/tb_mem_model.sv
      - sim/tb_icache_top.sv
